//--- flist.f
+incdir+include
src/uart_rx_pkg.sv
src/rx_framer.sv
src/rx_merge.sv
src/uart_rx_top.sv
tests/tb_uart_rx.sv

//--- include/uart_rx_macros.svh
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// clk_uart cycles per serial bit
`define UART_CLKS_PER_BIT 16

// Vote points as bit counter values
// The counter runs from CLKS_PER_BIT-2 down to 0 after the vote cycle,
// so offset k into a bit period sees the value CLKS_PER_BIT-1-k
`define UART_SAMPLE_1 (`UART_CLKS_PER_BIT - 1 - `UART_CLKS_PER_BIT / 4)
`define UART_SAMPLE_2 (`UART_CLKS_PER_BIT - 1 - `UART_CLKS_PER_BIT / 2)
`define UART_SAMPLE_3 (`UART_CLKS_PER_BIT - 1 - (3 * `UART_CLKS_PER_BIT) / 4)

`endif

//--- run.sh
#!/bin/sh
# Compile and run the UART receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_rx \
    -f flist.f -Mdir obj_dir -o tb_uart_rx
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_uart_rx > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

//--- src/rx_framer.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_framer (
    input  logic                  clk_uart,
    input  logic                  rst_n,
    input  logic                  rxd,
    output logic                  byte_valid,
    output uart_rx_pkg::rx_byte_t rx_data,
    output logic                  frame_err
);
    import uart_rx_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`UART_CLKS_PER_BIT - 2);
    localparam logic [CNT_W-1:0] SAMPLE_1 = CNT_W'(`UART_SAMPLE_1);
    localparam logic [CNT_W-1:0] SAMPLE_2 = CNT_W'(`UART_SAMPLE_2);
    localparam logic [CNT_W-1:0] SAMPLE_3 = CNT_W'(`UART_SAMPLE_3);
    // Start, eight data bits and stop
    localparam logic [3:0] FRAME_BITS = 4'd10;

    rx_state_e        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       votes;
    logic             vote;
    logic [3:0]       remain_bit;
    logic [8:0]       shift_reg;

    // Idle line is high
    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Two of three samples decide the bit
    assign vote = (votes[0] & votes[1]) | (votes[1] & votes[2]) | (votes[0] & votes[2]);

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            votes      <= '0;
            remain_bit <= '0;
            shift_reg  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!rxd_sync) begin
                        bit_cnt    <= CNT_LOAD;
                        remain_bit <= FRAME_BITS;
                        state      <= RX_WAIT;
                    end
                end
                RX_WAIT: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == SAMPLE_1 || bit_cnt == SAMPLE_2 || bit_cnt == SAMPLE_3) begin
                        votes <= {votes[1:0], rxd_sync};
                    end
                    if (bit_cnt == '0) begin
                        if (remain_bit == FRAME_BITS) begin
                            state <= RX_START_CHECK;
                        end else begin
                            state <= RX_SHIFT;
                        end
                    end
                end
                RX_START_CHECK: begin
                    if (!vote) begin
                        remain_bit <= remain_bit - 1'b1;
                        bit_cnt    <= CNT_LOAD;
                        state      <= RX_WAIT;
                    end else begin
                        // False start, back to idle quietly
                        state <= RX_IDLE;
                    end
                end
                RX_SHIFT: begin
                    shift_reg  <= {vote, shift_reg[8:1]};
                    remain_bit <= remain_bit - 1'b1;
                    if (remain_bit == 4'd1) begin
                        state <= RX_STOP_CHECK;
                    end else begin
                        bit_cnt <= CNT_LOAD;
                        state   <= RX_WAIT;
                    end
                end
                RX_STOP_CHECK: begin
                    state <= RX_DONE;
                end
                RX_DONE: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Stop bit sits in the top of the shifter
    assign byte_valid = (state == RX_STOP_CHECK) & shift_reg[8];
    assign frame_err  = (state == RX_STOP_CHECK) & ~shift_reg[8];
    assign rx_data    = shift_reg[7:0];

    a_strobes_exclusive: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        !(byte_valid && frame_err)
    );

    // Data still holds in the recovery cycle
    a_data_stable: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        byte_valid |=> $stable(rx_data)
    );

endmodule

`default_nettype wire

//--- src/rx_merge.sv
`timescale 1ns/10ps
`default_nettype none

module rx_merge (
    input  logic                  clk_uart,
    input  logic                  rst_n,
    input  logic [1:0]            byte_valid,
    input  uart_rx_pkg::rx_byte_t rx_data_0,
    input  uart_rx_pkg::rx_byte_t rx_data_1,
    input  logic                  out_ack,
    output logic                  out_req,
    output uart_rx_pkg::rx_byte_t out_data,
    output uart_rx_pkg::chan_t    out_chan,
    output logic [1:0]            overrun
);
    import uart_rx_pkg::*;

    merge_state_e state;
    rx_byte_t     in_data [2];
    rx_byte_t     slot_data [2];
    logic [1:0]   slot_full;
    chan_t        last_chan;
    chan_t        pick;
    logic         release_slot;

    assign in_data[0] = rx_data_0;
    assign in_data[1] = rx_data_1;

    // Alternate when both wait, else take the full one
    assign pick = (slot_full == 2'b11) ? ~last_chan : chan_t'(slot_full[1]);

    assign release_slot = (state == M_REQ) && out_ack;
    assign out_req      = (state == M_REQ);

    // Pending slots, a byte into a full slot is lost
    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            slot_full    <= '0;
            slot_data[0] <= '0;
            slot_data[1] <= '0;
            overrun      <= '0;
        end else begin
            overrun <= byte_valid & slot_full;
            for (int c = 0; c < 2; c++) begin
                if (byte_valid[c] && !slot_full[c]) begin
                    slot_full[c] <= 1'b1;
                    slot_data[c] <= in_data[c];
                end else if (release_slot && out_chan == chan_t'(c)) begin
                    slot_full[c] <= 1'b0;
                end
            end
        end
    end

    // Four-phase req/ack
    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state     <= M_IDLE;
            out_data  <= '0;
            out_chan  <= '0;
            last_chan <= 1'b1;
        end else begin
            case (state)
                M_IDLE: begin
                    if (|slot_full) begin
                        out_data <= slot_data[pick];
                        out_chan <= pick;
                        state    <= M_REQ;
                    end
                end
                M_REQ: begin
                    if (out_ack) begin
                        last_chan <= out_chan;
                        state     <= M_RELEASE;
                    end
                end
                M_RELEASE: begin
                    // Consumer must drop ack first
                    if (!out_ack) begin
                        state <= M_IDLE;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    a_req_hold: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_data) && $stable(out_chan)
    );

    a_no_req_on_ack: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        $rose(out_req) |-> !out_ack
    );

endmodule

`default_nettype wire

//--- src/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    // Framer states
    typedef enum logic [2:0] {
        RX_IDLE        = 3'd0,
        RX_WAIT        = 3'd1,
        RX_START_CHECK = 3'd2,
        RX_SHIFT       = 3'd3,
        RX_STOP_CHECK  = 3'd4,
        RX_DONE        = 3'd5
    } rx_state_e;

    // Output handshake states
    typedef enum logic [1:0] {
        M_IDLE    = 2'd0,
        M_REQ     = 2'd1,
        M_RELEASE = 2'd2
    } merge_state_e;

    typedef logic [7:0] rx_byte_t;

    // Channel number
    typedef logic chan_t;

endpackage

`default_nettype wire

//--- src/uart_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top (
    input  logic                  clk_uart,
    input  logic                  rst_n,
    input  logic [1:0]            rxd,
    input  logic                  out_ack,
    output logic                  out_req,
    output uart_rx_pkg::rx_byte_t out_data,
    output uart_rx_pkg::chan_t    out_chan,
    output logic [1:0]            frame_err,
    output logic [1:0]            overrun
);
    import uart_rx_pkg::*;

    logic [1:0] byte_valid;
    rx_byte_t   rx_data_0;
    rx_byte_t   rx_data_1;

    rx_framer u_framer_0 (
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rxd        (rxd[0]),
        .byte_valid (byte_valid[0]),
        .rx_data    (rx_data_0),
        .frame_err  (frame_err[0])
    );

    rx_framer u_framer_1 (
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rxd        (rxd[1]),
        .byte_valid (byte_valid[1]),
        .rx_data    (rx_data_1),
        .frame_err  (frame_err[1])
    );

    rx_merge u_merge (
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .rx_data_0  (rx_data_0),
        .rx_data_1  (rx_data_1),
        .out_ack    (out_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_chan   (out_chan),
        .overrun    (overrun)
    );

endmodule

`default_nettype wire

//--- tests/tb_uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_rx_macros.svh"

module tb_uart_rx;
    import uart_rx_pkg::*;

    localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;
    localparam int NO_GLITCH  = -1;

    logic       clk_uart = 1'b0;
    logic       rst_n = 1'b0;
    logic [1:0] rxd = 2'b11;
    logic       out_ack = 1'b0;
    logic       out_req;
    rx_byte_t   out_data;
    chan_t      out_chan;
    logic [1:0] frame_err;
    logic [1:0] overrun;

    integer     seed = 32'h851a_9ae7;
    rx_byte_t   exp_q0 [$];
    rx_byte_t   exp_q1 [$];
    rx_byte_t   expected;
    int         ferr_count [2] = '{0, 0};
    int         ovr_count [2] = '{0, 0};
    logic [1:0] ferr_allowed = 2'b00;
    logic [1:0] ovr_allowed = 2'b00;
    logic       quiet_window = 1'b0;
    logic       paused = 1'b0;
    int         ack_delay = 0;

    always #2 clk_uart = ~clk_uart;

    uart_rx_top i_dut (
        .clk_uart  (clk_uart),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .out_ack   (out_ack),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_chan  (out_chan),
        .frame_err (frame_err),
        .overrun   (overrun)
    );

    task automatic error_stop(input string what);
        $display("Error: %s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic mismatch_stop(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic rx_byte_t random_byte();
        return rx_byte_t'($random(seed));
    endfunction

    // Start bit, data LSB first, stop bit, then a short idle gap
    task automatic send_frame(input int ch, input rx_byte_t data, input logic stop_bit,
                              input int glitch_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        if (stop_bit && ch == 0) begin
            exp_q0.push_back(data);
        end else if (stop_bit) begin
            exp_q1.push_back(data);
        end
        for (int b = 0; b < 10; b++) begin
            for (int k = 0; k < BIT_CLKS; k++) begin
                @(posedge clk_uart);
                // One inverted cycle at the middle vote
                if (glitch_bit != NO_GLITCH && b == glitch_bit + 1 && k == BIT_CLKS / 2) begin
                    rxd[ch] <= ~frame[b];
                end else begin
                    rxd[ch] <= frame[b];
                end
            end
        end
        repeat (BIT_CLKS / 2) begin
            @(posedge clk_uart);
            rxd[ch] <= 1'b1;
        end
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q0.size() != 0 || exp_q1.size() != 0 || out_req || out_ack) begin
            @(posedge clk_uart);
            cycles++;
            if (cycles > limit) begin
                error_stop("Timed out waiting for the expected bytes to be delivered");
            end
        end
    endtask

    // Consumer, ack after 0 to 3 cycles
    always @(posedge clk_uart) begin
        if (!rst_n) begin
            out_ack <= 1'b0;
        end else if (out_ack) begin
            if (!out_req) begin
                out_ack <= 1'b0;
            end
        end else if (out_req && !paused && ack_delay == 0) begin
            out_ack <= 1'b1;
        end else if (out_req && !paused) begin
            ack_delay <= ack_delay - 1;
        end else begin
            ack_delay <= $random(seed) & 32'd3;
        end
    end

    // Scoreboard on each accepted transfer
    always @(posedge clk_uart) begin
        if (rst_n && out_req && out_ack) begin
            if (out_chan == 1'b0) begin
                assert (exp_q0.size() > 0) else error_stop("Unexpected byte on channel 0");
                expected = exp_q0.pop_front();
            end else begin
                assert (exp_q1.size() > 0) else error_stop("Unexpected byte on channel 1");
                expected = exp_q1.pop_front();
            end
            assert (out_data == expected)
                else mismatch_stop($sformatf("out_data (out_chan %0d)", out_chan),
                                   out_data, expected);
        end
    end

    always @(posedge clk_uart) begin
        if (rst_n) begin
            for (int c = 0; c < 2; c++) begin
                ferr_count[c] <= ferr_count[c] + int'(frame_err[c]);
                ovr_count[c]  <= ovr_count[c] + int'(overrun[c]);
            end
        end
    end

    a_ferr_allowed: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        (frame_err & ~ferr_allowed) == 2'b00
    ) else error_stop("frame_err pulsed on a channel that got no bad frame");

    a_ovr_allowed: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        (overrun & ~ovr_allowed) == 2'b00
    ) else error_stop("overrun pulsed while no byte could be lost");

    a_quiet: assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        quiet_window |-> !out_req
    ) else error_stop("out_req rose after a short low pulse on an idle line");

    initial begin
        rx_byte_t pair [4];
        repeat (8) @(posedge clk_uart);
        rst_n <= 1'b1;
        @(posedge clk_uart);
        assert (!out_req && frame_err == 2'b00 && overrun == 2'b00)
            else error_stop("Outputs are not idle after reset");

        for (int i = 0; i < 6; i++) begin
            send_frame(i / 3, random_byte(), 1'b1, NO_GLITCH);
        end
        wait_drained(2 * FRAME_CLKS);

        // Both lines start in the same cycle
        for (int i = 0; i < 4; i++) begin
            pair[i] = random_byte();
        end
        fork
            begin
                send_frame(0, pair[0], 1'b1, NO_GLITCH);
                send_frame(0, pair[1], 1'b1, NO_GLITCH);
            end
            begin
                send_frame(1, pair[2], 1'b1, NO_GLITCH);
                send_frame(1, pair[3], 1'b1, NO_GLITCH);
            end
        join
        wait_drained(2 * FRAME_CLKS);

        // Low pulse shorter than a quarter bit
        quiet_window <= 1'b1;
        @(posedge clk_uart);
        rxd[0] <= 1'b0;
        repeat (BIT_CLKS / 4 - 1) @(posedge clk_uart);
        rxd[0] <= 1'b1;
        repeat (2 * FRAME_CLKS) @(posedge clk_uart);
        quiet_window <= 1'b0;

        ferr_allowed <= 2'b10;
        send_frame(1, random_byte(), 1'b0, NO_GLITCH);
        wait_drained(FRAME_CLKS);
        ferr_allowed <= 2'b00;
        assert (ferr_count[1] == 1)
            else mismatch_stop("frame_err[1] pulse count", ferr_count[1], 1);

        send_frame(0, random_byte(), 1'b1, 3);
        send_frame(1, random_byte(), 1'b1, 6);
        wait_drained(2 * FRAME_CLKS);

        // Second byte hits a full slot while the consumer stalls
        paused <= 1'b1;
        ovr_allowed <= 2'b01;
        send_frame(0, random_byte(), 1'b1, NO_GLITCH);
        send_frame(0, random_byte(), 1'b1, NO_GLITCH);
        assert (ovr_count[0] == 1)
            else mismatch_stop("overrun[0] pulse count", ovr_count[0], 1);
        exp_q0.delete(exp_q0.size() - 1);
        ovr_allowed <= 2'b00;
        paused <= 1'b0;
        wait_drained(2 * FRAME_CLKS);

        if (exp_q0.size() == 0 && exp_q1.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            error_stop("Expected bytes were never delivered");
        end
    end

endmodule

`default_nettype wire
